// ==== design/dcache_writeback.sv ====
module dcache_writeback (
    input  logic           clk,
    input  logic           rstn,
    // Eviction request from the cache
    input  logic           evict_valid,
    output logic           evict_ready,
    input  wb_pkg::addr_t  evict_addr,
    input  logic           evict_dirty,
    input  wb_pkg::line_t  evict_line,
    // AXI write address
    output logic           awvalid,
    input  logic           awready,
    output wb_pkg::addr_t  awaddr,
    // AXI write data
    output logic           wvalid,
    input  logic           wready,
    output wb_pkg::word_t  wdata,
    output logic           wlast,
    // AXI write response
    input  logic           bvalid,
    output logic           bready,
    input  wb_pkg::resp_t  bresp,
    // Completion
    output logic           evict_done,
    output logic           evict_err
);

    wb_line_if line_if ();

    victim_buffer buffer_i (
        .clk         (clk),
        .rstn        (rstn),
        .evict_valid (evict_valid),
        .evict_ready (evict_ready),
        .evict_addr  (evict_addr),
        .evict_dirty (evict_dirty),
        .evict_line  (evict_line),
        .line        (line_if.buffer)
    );

    writeback_ctrl ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .line       (line_if.ctrl),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wlast      (wlast),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .evict_done (evict_done),
        .evict_err  (evict_err)
    );

endmodule

// ==== design/victim_buffer.sv ====
`include "wb_defs.svh"

module victim_buffer (
    input  logic           clk,
    input  logic           rstn,
    input  logic           evict_valid,
    output logic           evict_ready,
    input  wb_pkg::addr_t  evict_addr,
    input  logic           evict_dirty,
    input  wb_pkg::line_t  evict_line,
    wb_line_if.buffer      line
);

    // Byte offset bits inside one line
    localparam int OFFS_W = $clog2(`WB_BEATS * `WB_DATA_W / 8);

    logic           held;
    logic           accept;
    wb_pkg::addr_t  addr_q;
    logic           dirty_q;
    wb_pkg::line_t  line_q;

    // Only one line in flight
    assign evict_ready = !held;
    assign accept      = evict_valid && evict_ready;

    ////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (line.job_done) begin
            held <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Line storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            // Align to the start of the line
            addr_q  <= {evict_addr[`WB_ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
            dirty_q <= evict_dirty;
            line_q  <= evict_line;
        end
    end

    assign line.job_valid = held;
    assign line.job_dirty = dirty_q;
    assign line.job_addr  = addr_q;

    // Word mux by beat index
    assign line.beat_data = line_q[line.beat*`WB_DATA_W +: `WB_DATA_W];

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    // Cache keeps a waiting request steady until it is taken
    a_evict_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        evict_valid && !evict_ready |=> evict_valid && $stable(evict_addr)
            && $stable(evict_dirty) && $stable(evict_line)
    );

    // Controller must not release a buffer that holds nothing
    a_done_only_when_held: assert property (
        @(posedge clk) disable iff (!rstn)
        line.job_done |-> line.job_valid
    );

endmodule

// ==== design/wb_defs.svh ====
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Byte address width on the AXI side
`define WB_ADDR_W 32

// One AXI data beat, also one cache word
`define WB_DATA_W 32

// Words per cache line, sent as one INCR burst
`define WB_BEATS 4

`endif

// ==== design/wb_line_if.sv ====
interface wb_line_if;

    // Held line, owned by the victim buffer
    logic           job_valid;
    logic           job_dirty;
    wb_pkg::addr_t  job_addr;
    wb_pkg::word_t  beat_data;

    // Beat select and release, owned by the controller
    wb_pkg::beat_t  beat;
    logic           job_done;

    modport buffer (
        output job_valid,
        output job_dirty,
        output job_addr,
        output beat_data,
        input  beat,
        input  job_done
    );

    modport ctrl (
        input  job_valid,
        input  job_dirty,
        input  job_addr,
        input  beat_data,
        output beat,
        output job_done
    );

endinterface

// ==== design/wb_pkg.sv ====
`include "wb_defs.svh"

package wb_pkg;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////
    typedef logic [`WB_ADDR_W-1:0]             addr_t;
    typedef logic [`WB_DATA_W-1:0]             word_t;
    // Word 0 sits in the low bits
    typedef logic [`WB_BEATS*`WB_DATA_W-1:0]   line_t;
    typedef logic [$clog2(`WB_BEATS)-1:0]      beat_t;
    // 2'b00 is OKAY
    typedef logic [1:0]                        resp_t;

    ////////////////////////////////////////
    // Write-back controller states
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        SEND_ADDR,
        SEND_DATA,
        WAIT_RESP,
        RELEASE
    } wb_state_e;

endpackage

// ==== design/writeback_ctrl.sv ====
`include "wb_defs.svh"

module writeback_ctrl (
    input  logic           clk,
    input  logic           rstn,
    wb_line_if.ctrl        line,
    // AXI write address
    output logic           awvalid,
    input  logic           awready,
    output wb_pkg::addr_t  awaddr,
    // AXI write data
    output logic           wvalid,
    input  logic           wready,
    output wb_pkg::word_t  wdata,
    output logic           wlast,
    // AXI write response
    input  logic           bvalid,
    output logic           bready,
    input  wb_pkg::resp_t  bresp,
    // Completion
    output logic           evict_done,
    output logic           evict_err
);

    localparam wb_pkg::beat_t LAST_BEAT = wb_pkg::beat_t'(`WB_BEATS - 1);

    wb_pkg::wb_state_e  state;
    wb_pkg::wb_state_e  state_nxt;
    wb_pkg::beat_t      beat_q;
    wb_pkg::resp_t      resp_q;
    logic               aw_fire;
    logic               w_fire;
    logic               b_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= wb_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            wb_pkg::IDLE: begin
                // Clean lines skip the bus entirely
                if (line.job_valid) begin
                    state_nxt = line.job_dirty ? wb_pkg::SEND_ADDR : wb_pkg::RELEASE;
                end
            end
            wb_pkg::SEND_ADDR: begin
                if (aw_fire) begin
                    state_nxt = wb_pkg::SEND_DATA;
                end
            end
            wb_pkg::SEND_DATA: begin
                if (w_fire && beat_q == LAST_BEAT) begin
                    state_nxt = wb_pkg::WAIT_RESP;
                end
            end
            wb_pkg::WAIT_RESP: begin
                if (b_fire) begin
                    state_nxt = wb_pkg::RELEASE;
                end
            end
            wb_pkg::RELEASE: begin
                state_nxt = wb_pkg::IDLE;
            end
            default: begin
                state_nxt = wb_pkg::IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // Beat counter and response latch
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_q <= '0;
            resp_q <= '0;
        end else begin
            if (state == wb_pkg::IDLE) begin
                beat_q <= '0;
                resp_q <= '0;
            end else if (w_fire) begin
                beat_q <= beat_q + 1'b1;
            end
            if (b_fire) begin
                resp_q <= bresp;
            end
        end
    end

    // Channel valids straight from the state
    assign awvalid = (state == wb_pkg::SEND_ADDR);
    assign wvalid  = (state == wb_pkg::SEND_DATA);
    assign wlast   = wvalid && (beat_q == LAST_BEAT);
    assign bready  = (state == wb_pkg::WAIT_RESP);

    // Payload comes from the held buffer registers
    assign awaddr    = line.job_addr;
    assign wdata     = line.beat_data;
    assign line.beat = beat_q;

    assign line.job_done = (state == wb_pkg::RELEASE);
    assign evict_done    = line.job_done;
    assign evict_err     = evict_done && (resp_q != '0);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    // Buffer payload must not move during a W stall
    a_w_held: assert property (
        @(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast)
    );

    a_awvalid_held: assert property (
        @(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the write-back testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module dcache_writeback_tb -o dcache_writeback_tb \
    && ./obj_dir/dcache_writeback_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== FAIL ===" sim.log 2>/dev/null && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log 2>/dev/null || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"

// ==== verification/dcache_writeback_tb.sv ====
`include "wb_defs.svh"

module dcache_writeback_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_EVICT  = 8;
    localparam int MAX_WAIT = 200;

    typedef struct packed {
        wb_pkg::addr_t                  addr;
        logic                           dirty;
        wb_pkg::word_t [`WB_BEATS-1:0]  words;
        wb_pkg::resp_t                  resp;
    } evict_rec_t;

    logic           clk;
    logic           rstn;
    logic           evict_valid;
    logic           evict_ready;
    wb_pkg::addr_t  evict_addr;
    logic           evict_dirty;
    wb_pkg::line_t  evict_line;
    logic           awvalid;
    logic           awready = 1'b0;
    wb_pkg::addr_t  awaddr;
    logic           wvalid;
    logic           wready = 1'b0;
    wb_pkg::word_t  wdata;
    logic           wlast;
    logic           bvalid = 1'b0;
    logic           bready;
    wb_pkg::resp_t  bresp = 2'b00;
    logic           evict_done;
    logic           evict_err;

    evict_rec_t     evictions [N_EVICT];
    int             cur = 0;
    logic [31:0]    lfsr_q = 32'hb3e6ac73;
    logic           resp_pending = 1'b0;
    logic           in_flight = 1'b0;
    int             cyc = 0;
    int             accept_cyc = 0;
    int             aw_cnt = 0;
    int             w_cnt = 0;
    int             b_cnt = 0;

    tb_clock clock_i (.clk(clk), .rstn(rstn));

    dcache_writeback dcache_writeback_i (.*);

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else
            fail_run($sformatf("Fail at %0t: %s expected %0h got %0h", $time, name, exp, act));
    endtask

    // Words listed from 3 down to 0
    task automatic set_entry(input int idx, input wb_pkg::addr_t addr, input logic dirty,
                             input wb_pkg::line_t line, input wb_pkg::resp_t resp);
        evictions[idx].addr  = addr;
        evictions[idx].dirty = dirty;
        evictions[idx].words = line;
        evictions[idx].resp  = resp;
    endtask

    task automatic load_evictions();
        set_entry(0, 32'h8000_1230, 1'b1, {32'h3333_3333, 32'h2222_2222,
                  32'h1111_1111, 32'h0000_0000}, 2'b00);
        set_entry(1, 32'h0000_0a4c, 1'b0, {32'hdead_0003, 32'hdead_0002,
                  32'hdead_0001, 32'hdead_0000}, 2'b00);
        set_entry(2, 32'h4000_00f7, 1'b1, {32'hcafe_f00d, 32'h0bad_beef,
                  32'h1234_5678, 32'h9abc_def0}, 2'b10);
        set_entry(3, 32'hdead_beef, 1'b1, {32'h0000_0001, 32'h0000_0010,
                  32'h0000_0100, 32'h0000_1000}, 2'b00);
        // Clean line with an error code that must never reach evict_err
        set_entry(4, 32'h1234_5678, 1'b0, {32'h5555_aaaa, 32'haaaa_5555,
                  32'hffff_0000, 32'h0000_ffff}, 2'b11);
        set_entry(5, 32'hffff_fff0, 1'b1, {32'h8765_4321, 32'hfedc_ba98,
                  32'h0f0f_0f0f, 32'hf0f0_f0f0}, 2'b11);
        set_entry(6, 32'h0000_0004, 1'b1, {32'h7777_0007, 32'h6666_0006,
                  32'h5555_0005, 32'h4444_0004}, 2'b00);
        set_entry(7, 32'h0040_0038, 1'b1, {32'h0101_0101, 32'h0202_0202,
                  32'h0404_0404, 32'h0808_0808}, 2'b01);
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!evict_done && n < MAX_WAIT);
        assert (evict_done) else fail_run("No evict_done within the allowed cycles");
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////
    // AXI slave with random stalls
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rstn) begin
            lfsr_q = lfsr_step(lfsr_q);
            awready <= lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
            wready <= lfsr_q[0];
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (resp_pending && !bvalid) begin
                lfsr_q = lfsr_step(lfsr_q);
                if (lfsr_q[0]) begin
                    bvalid       <= 1'b1;
                    bresp        <= evictions[cur].resp;
                    resp_pending <= 1'b0;
                end
            end
            if (wvalid && wready && wlast) begin
                resp_pending <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Bus monitor, sampled mid cycle
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rstn) begin
            if (evict_valid && evict_ready) begin
                aw_cnt     = 0;
                w_cnt      = 0;
                b_cnt      = 0;
                accept_cyc = cyc;
                in_flight  = 1'b1;
            end else if (in_flight) begin
                assert (!evict_ready) else fail_run("evict_ready high while a line is in flight");
            end
            if (awvalid && awready) begin
                assert (evictions[cur].dirty) else fail_run("AW transfer for a clean line");
                assert (aw_cnt == 0) else fail_run("Second AW transfer in one eviction");
                check_value("awaddr", {evictions[cur].addr[31:4], 4'h0}, awaddr);
                aw_cnt++;
            end
            if (wvalid && wready) begin
                assert (evictions[cur].dirty && w_cnt < `WB_BEATS) else
                    fail_run("W transfer that no eviction asked for");
                check_value("wdata", evictions[cur].words[w_cnt[1:0]], wdata);
                check_value("wlast", 32'(w_cnt == `WB_BEATS - 1), 32'(wlast));
                w_cnt++;
            end
            if (bvalid && bready) begin
                b_cnt++;
            end
            if (evict_done) begin
                assert (in_flight) else fail_run("evict_done without an eviction in flight");
                check_value("evict_err",
                            32'(evictions[cur].dirty && evictions[cur].resp != 2'b00),
                            32'(evict_err));
                if (evictions[cur].dirty) begin
                    check_value("AW transfers before evict_done", 1, aw_cnt);
                    check_value("W transfers before evict_done", `WB_BEATS, w_cnt);
                    check_value("B transfers before evict_done", 1, b_cnt);
                end else begin
                    check_value("clean evict_done cycles after accept", 2, cyc - accept_cyc);
                end
                in_flight = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    initial begin
        evict_valid <= 1'b0;
        evict_addr  <= '0;
        evict_dirty <= 1'b0;
        evict_line  <= '0;
        load_evictions();
        wait (rstn === 1'b1);
        @(negedge clk);
        check_value("evict_ready after reset", 1, 32'(evict_ready));
        check_value("awvalid after reset", 0, 32'(awvalid));
        check_value("wvalid after reset", 0, 32'(wvalid));
        check_value("bready after reset", 0, 32'(bready));
        check_value("evict_done after reset", 0, 32'(evict_done));
        for (int i = 0; i < N_EVICT; i++) begin
            @(posedge clk);
            cur         <= i;
            evict_valid <= 1'b1;
            evict_addr  <= evictions[i].addr;
            evict_dirty <= evictions[i].dirty;
            evict_line  <= evictions[i].words;
            do begin
                @(posedge clk);
            end while (!evict_ready);
            evict_valid <= 1'b0;
            wait_for_done();
        end
        // A few idle cycles to catch a stray pulse
        repeat (5) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (10 + N_EVICT * MAX_WAIT) @(posedge clk);
        fail_run("Watchdog timeout, the evictions did not finish in time");
    end

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rstn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/wb_pkg.sv
design/wb_line_if.sv
design/victim_buffer.sv
design/writeback_ctrl.sv
design/dcache_writeback.sv
verification/tb_clock.sv
verification/dcache_writeback_tb.sv
